/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_DOUBLE  = 3'b011; // LD and SD
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic       valid;
        logic [6:0] opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [2:0] funct3;
        logic       funct7_5;  // Selects SUB on R-type
        xlen_t      imm;       // I-type or S-type, sign extended
    } if_id_t;

    typedef struct packed {
        logic    alu_src;      // Second ALU input is the immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     val_a;
        xlen_t     val_b;
        xlen_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t rd;
        xlen_t     alu_result;  // Also the memory address
        xlen_t     store_data;
    } ex_mem_t;

    // One register write, valid only for rd != 0
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

endpackage

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic [31:0]    instr,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       supported;
    xlen_t      imm_i;
    xlen_t      imm_s;
    if_id_t     if_id_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    // Only listed opcode/funct3 pairs pass, the rest turn into bubbles
    always_comb begin
        case (opcode)
            OP_REG, OP_IMM: begin
                supported = (funct3 == F3_ADD_SUB) || (funct3 == F3_XOR) ||
                            (funct3 == F3_OR) || (funct3 == F3_AND);
            end
            OP_LOAD, OP_STORE: begin
                supported = (funct3 == F3_DOUBLE);
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    always_comb begin
        if_id_next.valid    = supported;
        if_id_next.opcode   = opcode;
        if_id_next.rd       = instr[11:7];
        if_id_next.rs1      = instr[19:15];
        if_id_next.rs2      = instr[24:20];
        if_id_next.funct3   = funct3;
        if_id_next.funct7_5 = instr[30];
        if_id_next.imm      = (opcode == OP_STORE) ? imm_s : imm_i;  // S-type only for stores
    end

    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id <= '0;
        end else begin
            if_id <= if_id_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::xlen_t     rd_val_a,
    output rv_pkg::xlen_t     rd_val_b,
    input  rv_pkg::wb_t       wb
);
    import rv_pkg::*;

    // x0 has no storage
    xlen_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= xlen_t'(i);  // Each register starts at its own index
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write in the same cycle wins over the stored value
    assign rd_val_a = (rs1 == '0) ? '0 :
                      (wb.valid && wb.rd == rs1) ? wb.data :
                      regs[rs1];

    assign rd_val_b = (rs2 == '0) ? '0 :
                      (wb.valid && wb.rd == rs2) ? wb.data :
                      regs[rs2];

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::if_id_t if_id,
    input  rv_pkg::wb_t    wb,
    output rv_pkg::id_ex_t id_ex
);
    import rv_pkg::*;

    ctrl_t  ctrl;
    xlen_t  val_a;
    xlen_t  val_b;
    id_ex_t id_ex_next;

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (if_id.rs1),
        .rs2      (if_id.rs2),
        .rd_val_a (val_a),
        .rd_val_b (val_b),
        .wb       (wb)
    );

    // ALU operation from funct3, SUB only on R-type
    function automatic alu_op_e alu_op_of(input logic [2:0] funct3, input logic is_sub);
        case (funct3)
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return is_sub ? ALU_SUB : ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;  // Bubbles keep all-zero control
        if (if_id.valid) begin
            case (if_id.opcode)
                OP_REG: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = alu_op_of(if_id.funct3, if_id.funct7_5);
                end
                OP_IMM: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op    = alu_op_of(if_id.funct3, 1'b0);
                end
                OP_LOAD: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                end
                OP_STORE: begin
                    ctrl.alu_src   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

    always_comb begin
        id_ex_next.valid = if_id.valid;
        id_ex_next.ctrl  = ctrl;
        id_ex_next.rs1   = if_id.rs1;
        id_ex_next.rs2   = if_id.rs2;
        id_ex_next.rd    = if_id.rd;
        id_ex_next.val_a = val_a;
        id_ex_next.val_b = val_b;
        id_ex_next.imm   = if_id.imm;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::id_ex_t  id_ex,
    input  rv_pkg::wb_t     mem_fwd,
    input  rv_pkg::wb_t     wb,
    output rv_pkg::ex_mem_t ex_mem
);
    import rv_pkg::*;

    xlen_t   fwd_a;
    xlen_t   fwd_b;
    xlen_t   alu_b;
    xlen_t   alu_result;
    ex_mem_t ex_mem_next;

    // Nearer write first, then MEM/WB, then the value read in decode
    function automatic xlen_t forward(
        input reg_addr_t src,
        input xlen_t     reg_val,
        input wb_t       near,
        input wb_t       far
    );
        if (near.valid && near.rd == src) begin
            return near.data;
        end else if (far.valid && far.rd == src) begin
            return far.data;
        end else begin
            return reg_val;
        end
    endfunction

    assign fwd_a = forward(id_ex.rs1, id_ex.val_a, mem_fwd, wb);
    assign fwd_b = forward(id_ex.rs2, id_ex.val_b, mem_fwd, wb);

    assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = fwd_a - alu_b;
            ALU_AND: alu_result = fwd_a & alu_b;
            ALU_OR:  alu_result = fwd_a | alu_b;
            ALU_XOR: alu_result = fwd_a ^ alu_b;
            default: alu_result = fwd_a + alu_b;  // ADD, also load/store address
        endcase
    end

    always_comb begin
        ex_mem_next.valid      = id_ex.valid;
        ex_mem_next.reg_write  = id_ex.ctrl.reg_write && (id_ex.rd != '0);  // x0 never written
        ex_mem_next.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_next.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_next.rd         = id_ex.rd;
        ex_mem_next.alu_result = alu_result;
        ex_mem_next.store_data = fwd_b;
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::wb_t     mem_fwd,
    output rv_pkg::wb_t     wb
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    xlen_t            dmem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    xlen_t            load_data;

    // Doubleword index, wraps modulo the memory depth
    assign word_idx  = ex_mem.alu_result[3 +: IDX_W];
    assign load_data = dmem[word_idx];  // Asynchronous read

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= 64'h1000 + xlen_t'(i);
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    // Write-back data as seen by the forwarding path
    always_comb begin
        mem_fwd.valid = ex_mem.valid && ex_mem.reg_write;
        mem_fwd.rd    = ex_mem.rd;
        mem_fwd.data  = ex_mem.mem_read ? load_data : ex_mem.alu_result;
    end

    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= mem_fwd;
        end
    end

endmodule

`default_nettype wire

/* rtl/riscv_pipeline.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_pipeline #(
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       instr,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::xlen_t     wb_data
);
    import rv_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    wb_t     mem_fwd;  // Combinational, from EX/MEM
    wb_t     wb;       // Registered MEM/WB

    fetch_stage fetch_stage_i (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .if_id (if_id)
    );

    decode_stage decode_stage_i (
        .clk   (clk),
        .reset (reset),
        .if_id (if_id),
        .wb    (wb),
        .id_ex (id_ex)
    );

    execute_stage execute_stage_i (
        .clk     (clk),
        .reset   (reset),
        .id_ex   (id_ex),
        .mem_fwd (mem_fwd),
        .wb      (wb),
        .ex_mem  (ex_mem)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory_stage_i (
        .clk     (clk),
        .reset   (reset),
        .ex_mem  (ex_mem),
        .mem_fwd (mem_fwd),
        .wb      (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

`default_nettype wire

/* verif/riscv_pipeline_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module riscv_pipeline_tb;
    import rv_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 3;
    localparam int          DMEM_WORDS   = 64;
    localparam int          LINE_DEPTH   = 5;  // Input word plus four pipeline cycles
    localparam int          RANDOM_WORDS = 300;
    localparam logic [31:0] LFSR_SEED    = 32'h75db_0e27;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    xlen_t       wb_data;

    logic [31:0] lfsr_state;
    logic [63:0] model_regs [32];
    logic [63:0] model_mem [DMEM_WORDS];
    wb_t         exp_line [LINE_DEPTH];  // Entry 0 is the word on the input
    string       name_line [LINE_DEPTH];
    wb_t         exp_now;
    logic [31:0] words [$];
    string       names [$];
    bit          stream_ready;

    riscv_pipeline riscv_pipeline_i (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign exp_now = exp_line[LINE_DEPTH-1];

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    function automatic logic [31:0] r_type_word(input logic f7_5, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {1'b0, f7_5, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    // Ops 0 to 4 are ADD SUB AND OR XOR, 5 to 8 the immediate forms
    function automatic logic [31:0] alu_word(input int op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
        case (op)
            0:       return r_type_word(1'b0, rs2, rs1, 3'b000, rd);
            1:       return r_type_word(1'b1, rs2, rs1, 3'b000, rd);
            2:       return r_type_word(1'b0, rs2, rs1, 3'b111, rd);
            3:       return r_type_word(1'b0, rs2, rs1, 3'b110, rd);
            4:       return r_type_word(1'b0, rs2, rs1, 3'b100, rd);
            5:       return i_type_word(imm, rs1, 3'b000, rd, OP_IMM);
            6:       return i_type_word(imm, rs1, 3'b111, rd, OP_IMM);
            7:       return i_type_word(imm, rs1, 3'b110, rd, OP_IMM);
            default: return i_type_word(imm, rs1, 3'b100, rd, OP_IMM);
        endcase
    endfunction

    // Architectural effect of one word, straight from the ISA subset
    task automatic execute_reference(input logic [31:0] word, output wb_t result);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] op_b;
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] value;
        logic        writes;
        int          idx;
        opcode = word[6:0];
        f3     = word[14:12];
        rd     = word[11:7];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm_i  = {{52{word[31]}}, word[31:20]};
        imm_s  = {{52{word[31]}}, word[31:25], word[11:7]};
        op_b   = (opcode == OP_IMM) ? imm_i : b;
        value  = '0;
        writes = 1'b0;
        if (opcode == OP_REG || opcode == OP_IMM) begin
            writes = 1'b1;
            case (f3)
                3'b000:  value = (opcode == OP_REG && word[30]) ? a - op_b : a + op_b;
                3'b100:  value = a ^ op_b;
                3'b110:  value = a | op_b;
                3'b111:  value = a & op_b;
                default: writes = 1'b0;
            endcase
        end else if (opcode == OP_LOAD && f3 == 3'b011) begin
            idx    = int'(((a + imm_i) >> 3) % 64'(DMEM_WORDS));
            value  = model_mem[idx];
            writes = 1'b1;
        end else if (opcode == OP_STORE && f3 == 3'b011) begin
            idx            = int'(((a + imm_s) >> 3) % 64'(DMEM_WORDS));
            model_mem[idx] = b;
        end
        result = '0;
        if (writes && rd != 5'd0) begin
            model_regs[rd] = value;
            result.valid   = 1'b1;
            result.rd      = rd;
            result.data    = value;
        end
    endtask

    task automatic queue_word(input logic [31:0] word, input string name);
        words.push_back(word);
        names.push_back(name);
    endtask

    task automatic drive_word(input logic [31:0] word, input string name);
        wb_t expected;
        @(posedge clk);
        #1;
        instr = word;
        execute_reference(word, expected);
        for (int j = LINE_DEPTH - 1; j > 0; j--) begin
            exp_line[j]  = exp_line[j-1];
            name_line[j] = name_line[j-1];
        end
        exp_line[0]  = expected;
        name_line[0] = name;
    endtask

    task automatic report_mismatch(input string field, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %s %s: expected %h, actual %h", name_line[LINE_DEPTH-1], field,
                 expected, actual);
        $display("FAIL: see errors above");
        $fatal(1, "write-back mismatch");
    endtask

    // Copies of untouched registers, x0 last
    task automatic reset_state_stream();
        logic [4:0] srcs [5] = '{5'd1, 5'd2, 5'd17, 5'd31, 5'd0};
        for (int i = 0; i < 5; i++) begin
            queue_word(i_type_word(12'd0, srcs[i], 3'b000, 5'd20 + 5'(i), OP_IMM),
                       "reset_state");
        end
    endtask

    task automatic alu_forwarding_stream();
        logic [11:0] imm;
        for (int op = 0; op < 9; op++) begin
            imm = 12'(take_bits(12));
            queue_word(i_type_word(12'(take_bits(12)), 5'd0, 3'b000, 5'd1, OP_IMM),
                       "alu_forwarding");
            queue_word(alu_word(op, 5'd2, 5'd1, 5'd1, imm), "alu_forwarding");  // Distance 1
            queue_word(alu_word(op, 5'd3, 5'd2, 5'd1, imm), "alu_forwarding");  // 1 and 2
            queue_word(alu_word(op, 5'd4, 5'd1, 5'd2, imm), "alu_forwarding");  // 3 and 2
            queue_word(alu_word(op, 5'd5, 5'd4, 5'd3, imm), "alu_forwarding");
            queue_word(alu_word(op, 5'd6, 5'd3, 5'd5, imm), "alu_forwarding");  // 3 and 1
        end
    endtask

    task automatic load_store_stream();
        queue_word(i_type_word(12'd16, 5'd0, 3'b011, 5'd6, OP_LOAD), "load_store");
        queue_word(i_type_word(12'd504, 5'd0, 3'b011, 5'd7, OP_LOAD), "load_store");
        queue_word(i_type_word(12'd64, 5'd0, 3'b000, 5'd5, OP_IMM), "load_store");
        queue_word(s_type_word(12'd8, 5'd7, 5'd5, 3'b011), "load_store");  // Base and data forwarded
        queue_word(i_type_word(12'd72, 5'd0, 3'b011, 5'd8, OP_LOAD), "load_store");
        queue_word(r_type_word(1'b0, 5'd8, 5'd8, 3'b000, 5'd9), "load_store");  // Uses load at once
        queue_word(s_type_word(12'd0, 5'd9, 5'd5, 3'b011), "load_store");
        queue_word(i_type_word(12'd64, 5'd0, 3'b011, 5'd10, OP_LOAD), "load_store");
        queue_word(r_type_word(1'b0, 5'd6, 5'd10, 3'b100, 5'd11), "load_store");
    endtask

    task automatic bubbles_stream();
        queue_word(i_type_word(12'h123, 5'd0, 3'b000, 5'd12, OP_IMM), "bubbles_and_x0");
        queue_word(32'h0000_0000, "bubbles_and_x0");
        queue_word(32'hffff_ffff, "bubbles_and_x0");
        queue_word(r_type_word(1'b0, 5'd12, 5'd12, 3'b001, 5'd13), "bubbles_and_x0");
        queue_word(i_type_word(12'd5, 5'd12, 3'b000, 5'd0, OP_IMM), "bubbles_and_x0");
        queue_word(r_type_word(1'b0, 5'd12, 5'd13, 3'b000, 5'd14), "bubbles_and_x0");
        queue_word(r_type_word(1'b0, 5'd12, 5'd12, 3'b000, 5'd0), "bubbles_and_x0");
        queue_word(r_type_word(1'b0, 5'd12, 5'd0, 3'b000, 5'd15), "bubbles_and_x0");  // x0 right after
        queue_word(i_type_word(12'd0, 5'd0, 3'b010, 5'd16, OP_LOAD), "bubbles_and_x0");
        queue_word(s_type_word(12'd160, 5'd12, 5'd0, 3'b010), "bubbles_and_x0");
        queue_word(i_type_word(12'd160, 5'd0, 3'b011, 5'd16, OP_LOAD), "bubbles_and_x0");
        queue_word(r_type_word(1'b0, 5'd13, 5'd16, 3'b000, 5'd17), "bubbles_and_x0");
    endtask

    // Registers x0 to x7, memory addressed off x0 so it stays in range
    task automatic random_stream();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] word;
        for (int n = 0; n < RANDOM_WORDS; n++) begin
            kind = 3'(take_bits(3));
            rd   = 5'(take_bits(3));
            rs1  = 5'(take_bits(3));
            rs2  = 5'(take_bits(3));
            imm  = 12'(take_bits(12));
            case (kind)
                3'd5: word = i_type_word({3'b0, 6'(take_bits(6)), 3'b0}, 5'd0, 3'b011, rd,
                                         OP_LOAD);
                3'd6: word = s_type_word({3'b0, 6'(take_bits(6)), 3'b0}, rs2, 5'd0, 3'b011);
                3'd7: begin
                    if (take_bits(1) == 32'd1) begin
                        word = r_type_word(1'b0, rs2, rs1, 3'b001, rd);  // Shift, unsupported
                    end else begin
                        word      = take_bits(32);
                        word[6:0] = 7'b1100011;  // Branch opcode
                    end
                end
                default: word = alu_word(int'(take_bits(4)) % 9, rd, rs1, rs2, imm);
            endcase
            queue_word(word, "random_stream");
        end
    endtask

    check_valid: assert property (@(posedge clk) wb_valid == exp_now.valid)
        else report_mismatch("wb_valid", 64'(exp_now.valid), 64'($sampled(wb_valid)));

    check_rd: assert property (@(posedge clk) !exp_now.valid || wb_rd == exp_now.rd)
        else report_mismatch("wb_rd", 64'(exp_now.rd), 64'($sampled(wb_rd)));

    check_data: assert property (@(posedge clk) !exp_now.valid || wb_data == exp_now.data)
        else report_mismatch("wb_data", exp_now.data, $sampled(wb_data));

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 64'(i);  // x0 stays zero
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = 64'h1000 + 64'(i);
        end
        for (int j = 0; j < LINE_DEPTH; j++) begin
            exp_line[j]  = '0;
            name_line[j] = "reset_state";
        end
        reset_state_stream();
        alu_forwarding_stream();
        load_store_stream();
        bubbles_stream();
        random_stream();
        stream_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (words[i]) begin
            drive_word(words[i], names[i]);
        end
        repeat (LINE_DEPTH) drive_word(32'h0, "drain");  // Let the last word reach the checks
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        wait (stream_ready);
        #(CLK_PERIOD * (words.size() + RESET_CYCLES + 20));
        $display("Timeout: the instruction stream did not drain in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/riscv_pipeline.sv
verif/riscv_pipeline_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench, exit status comes from the simulator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module riscv_pipeline_tb \
    -f sim.f \
    -o riscv_pipeline_sim

./obj_dir/riscv_pipeline_sim
